/* rtl/soc_defines.svh */
/*
 * SoC configuration macros: bus widths, memory size and the address map
 */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// host bus
`define SOC_ADDR_W 16
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// clusters and L2
`define SOC_N_CLUSTERS 2
`define SOC_L2_WORDS 256
`define SOC_RUN_W 16

// address map, L2 spans 0x0000 to 0x03ff
`define SOC_L2_BASE 16'h0000
`define SOC_CL_BASE 16'h1000
`define SOC_CL_STRIDE 16'h0010
`define SOC_CL_REG_CMD 4'h0
`define SOC_CL_REG_RUN 4'h4
`define SOC_CL_REG_STATUS 4'h8

`endif

/* rtl/apb_pkg.sv */
/*
 * APB types for the host port and the internal target ports
 */
`include "soc_defines.svh"

package apb_pkg;

  typedef logic [`SOC_ADDR_W-1:0] apb_addr_t;
  typedef logic [`SOC_DATA_W-1:0] apb_data_t;
  typedef logic [`SOC_STRB_W-1:0] apb_strb_t;

  // requester to completer, 55 bits
  typedef struct packed {
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_strb_t pstrb;
  } apb_req_t;

  // completer to requester, 34 bits
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_resp_t;

endpackage

/* rtl/cluster_pkg.sv */
/*
 * Cluster sequencer types: life-cycle states and control opcodes
 */
`include "soc_defines.svh"

package cluster_pkg;

  // cluster life cycle
  typedef enum logic [1:0] {
    CL_IDLE = 2'd0,
    CL_BUSY = 2'd1,
    CL_DONE = 2'd2
  } cl_state_e;

  // opcodes written to the CMD register
  typedef enum logic [7:0] {
    CMD_NOP   = 8'h00,
    CMD_START = 8'h01,
    CMD_STOP  = 8'h02,
    CMD_CLEAR = 8'h03
  } cl_cmd_e;

  typedef logic [`SOC_RUN_W-1:0] cl_run_t;

endpackage

/* rtl/l2_mem.sv */
/*
 * L2 memory, word array on a zero-wait-state APB port with byte strobes
 */
`timescale 1ns/1ps
`include "soc_defines.svh"

module l2_mem (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  apb_pkg::apb_req_t  req_i,
  output apb_pkg::apb_resp_t resp_o
);

  import apb_pkg::*;

  localparam int unsigned IDX_W = $clog2(`SOC_L2_WORDS);

  apb_data_t        mem_q [`SOC_L2_WORDS];
  apb_addr_t        word_off;
  logic [IDX_W-1:0] word_idx;
  logic             access;
  logic             wr_en;

  // word index within the L2 region
  assign word_off = req_i.paddr - apb_addr_t'(`SOC_L2_BASE);
  assign word_idx = word_off[IDX_W+1:2];

  assign access = req_i.psel & req_i.penable;
  // no writes land while reset is held
  assign wr_en  = access & req_i.pwrite & arst_n_i;

  // byte lanes written at the end of the access cycle
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (req_i.pstrb[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.pwdata[8*b +: 8];
        end
      end
    end
  end

  // read data is combinational in the access cycle
  always_comb begin
    resp_o.prdata  = '0;
    resp_o.pready  = 1'b1;
    resp_o.pslverr = 1'b0;
    if (req_i.psel && !req_i.pwrite) begin
      resp_o.prdata = mem_q[word_idx];
    end
  end

endmodule

/* rtl/cluster_fsm.sv */
/*
 * Cluster sequencer, idle/busy/done life cycle with a run-length down-counter
 */
`timescale 1ns/1ps

module cluster_fsm (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   fetch_en_i,
  input  logic                   cmd_valid_i,
  input  cluster_pkg::cl_cmd_e   cmd_i,
  input  cluster_pkg::cl_run_t   run_cycles_i,
  output cluster_pkg::cl_state_e state_o
);

  import cluster_pkg::*;

  cl_state_e state_q, state_d;
  cl_run_t   cnt_q, cnt_d;
  logic      start;

  // command start and fetch-enable lead to the same transition
  assign start = (cmd_valid_i && cmd_i == CMD_START) || fetch_en_i;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      CL_IDLE: begin
        if (start) begin
          state_d = CL_BUSY;
          // busy for run cycles, at least one
          cnt_d = (run_cycles_i == '0) ? '0 : run_cycles_i - cl_run_t'(1);
        end
      end
      CL_BUSY: begin
        if (cmd_valid_i && cmd_i == CMD_STOP) begin
          state_d = CL_IDLE;
        end else if (cnt_q == '0) begin
          state_d = CL_DONE;
        end else begin
          cnt_d = cnt_q - cl_run_t'(1);
        end
      end
      CL_DONE: begin
        // eoc held until cleared
        if (cmd_valid_i && cmd_i == CMD_CLEAR) begin
          state_d = CL_IDLE;
        end
      end
      default: state_d = CL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign state_o = state_q;

endmodule

/* rtl/cluster_ctrl.sv */
/*
 * Cluster control block, per-cluster CMD/RUN/STATUS registers and
 * one sequencer per cluster
 */
`timescale 1ns/1ps
`include "soc_defines.svh"

module cluster_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  apb_pkg::apb_req_t          req_i,
  output apb_pkg::apb_resp_t         resp_o,
  input  logic [`SOC_N_CLUSTERS-1:0] fetch_en_i,
  output logic [`SOC_N_CLUSTERS-1:0] busy_o,
  output logic [`SOC_N_CLUSTERS-1:0] eoc_o
);

  import apb_pkg::*;
  import cluster_pkg::*;

  localparam int unsigned OFF_W = $clog2(`SOC_CL_STRIDE);
  localparam int unsigned IDX_W = `SOC_ADDR_W - OFF_W;

  apb_addr_t                  cl_off;
  logic [IDX_W-1:0]           cl_idx;
  logic [OFF_W-1:0]           reg_off;
  logic                       access;
  logic                       is_cmd, is_run, is_status;
  logic                       op_known;
  logic                       err;
  cl_cmd_e                    cmd_op;
  logic [`SOC_N_CLUSTERS-1:0] sel;
  logic [`SOC_N_CLUSTERS-1:0] cmd_valid;
  cl_run_t                    run_q [`SOC_N_CLUSTERS];
  cl_state_e                  state [`SOC_N_CLUSTERS];
  apb_data_t                  rd_data;

  // split the region offset into cluster index and register offset
  assign cl_off  = req_i.paddr - apb_addr_t'(`SOC_CL_BASE);
  assign cl_idx  = cl_off[`SOC_ADDR_W-1:OFF_W];
  assign reg_off = cl_off[OFF_W-1:0];

  assign access    = req_i.psel & req_i.penable;
  assign is_cmd    = reg_off == `SOC_CL_REG_CMD;
  assign is_run    = reg_off == `SOC_CL_REG_RUN;
  assign is_status = reg_off == `SOC_CL_REG_STATUS;
  assign cmd_op    = cl_cmd_e'(req_i.pwdata[7:0]);

  always_comb begin
    op_known = 1'b0;
    case (cmd_op)
      CMD_NOP, CMD_START, CMD_STOP, CMD_CLEAR: op_known = 1'b1;
      default: op_known = 1'b0;
    endcase
  end

  // bad index, bad offset or illegal direction/opcode
  assign err = ~(|sel) | ~(is_cmd | is_run | is_status)
             | (req_i.pwrite & is_status) | (~req_i.pwrite & is_cmd)
             | (req_i.pwrite & is_cmd & ~op_known);

  for (genvar i = 0; i < `SOC_N_CLUSTERS; i++) begin : gen_clusters
    assign sel[i]       = cl_idx == IDX_W'(i);
    assign cmd_valid[i] = access & req_i.pwrite & sel[i] & is_cmd & op_known;

    cluster_fsm i_cluster_fsm (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .fetch_en_i   (fetch_en_i[i]),
      .cmd_valid_i  (cmd_valid[i]),
      .cmd_i        (cmd_op),
      .run_cycles_i (run_q[i]),
      .state_o      (state[i])
    );

    assign busy_o[i] = state[i] == CL_BUSY;
    assign eoc_o[i]  = state[i] == CL_DONE;
  end

  // RUN registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `SOC_N_CLUSTERS; i++) begin
        run_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `SOC_N_CLUSTERS; i++) begin
        if (access && req_i.pwrite && sel[i] && is_run) begin
          run_q[i] <= req_i.pwdata[`SOC_RUN_W-1:0];
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    for (int i = 0; i < `SOC_N_CLUSTERS; i++) begin
      if (sel[i]) begin
        if (is_run) begin
          rd_data = apb_data_t'(run_q[i]);
        end else if (is_status) begin
          rd_data = apb_data_t'(state[i]);
        end
      end
    end
  end

  assign resp_o.prdata  = (req_i.psel && !req_i.pwrite && !err) ? rd_data : '0;
  assign resp_o.pready  = 1'b1;
  assign resp_o.pslverr = access & err;

endmodule

/* rtl/soc_bus.sv */
/*
 * SoC bus, routes host APB transfers to L2 or cluster control and merges
 * the responses, answering unmapped addresses with an error
 */
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_bus (
  input  apb_pkg::apb_req_t  host_req_i,
  output apb_pkg::apb_resp_t host_resp_o,
  output apb_pkg::apb_req_t  l2_req_o,
  input  apb_pkg::apb_resp_t l2_resp_i,
  output apb_pkg::apb_req_t  cl_req_o,
  input  apb_pkg::apb_resp_t cl_resp_i
);

  import apb_pkg::*;

  // byte spans of the two regions
  localparam apb_addr_t L2_SPAN = apb_addr_t'(`SOC_L2_WORDS * 4);
  // whole 4 KiB page so that cluster control sees out-of-range indices
  localparam apb_addr_t CL_SPAN = apb_addr_t'(16'h1000);

  apb_addr_t l2_off;
  apb_addr_t cl_off;
  logic      l2_hit;
  logic      cl_hit;

  assign l2_off = host_req_i.paddr - apb_addr_t'(`SOC_L2_BASE);
  assign cl_off = host_req_i.paddr - apb_addr_t'(`SOC_CL_BASE);
  assign l2_hit = l2_off < L2_SPAN;
  assign cl_hit = cl_off < CL_SPAN;

  // same request to both targets, psel only where it hits
  always_comb begin
    l2_req_o      = host_req_i;
    l2_req_o.psel = host_req_i.psel & l2_hit;
    cl_req_o      = host_req_i;
    cl_req_o.psel = host_req_i.psel & cl_hit;
  end

  always_comb begin
    if (l2_hit) begin
      host_resp_o = l2_resp_i;
    end else if (cl_hit) begin
      host_resp_o = cl_resp_i;
    end else begin
      // unmapped
      host_resp_o.prdata  = '0;
      host_resp_o.pready  = 1'b1;
      host_resp_o.pslverr = host_req_i.psel & host_req_i.penable;
    end
  end

endmodule

/* rtl/pulp_soc.sv */
/*
 * PULP SoC shell, host APB port into the SoC bus, L2 memory and
 * cluster control
 */
`timescale 1ns/1ps
`include "soc_defines.svh"

module pulp_soc (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  apb_pkg::apb_req_t          apb_req_i,
  output apb_pkg::apb_resp_t         apb_resp_o,
  input  logic [`SOC_N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [`SOC_N_CLUSTERS-1:0] cl_busy_o,
  output logic [`SOC_N_CLUSTERS-1:0] cl_eoc_o
);

  import apb_pkg::*;

  // target ports of the bus
  apb_req_t  l2_req;
  apb_resp_t l2_resp;
  apb_req_t  cl_req;
  apb_resp_t cl_resp;

  soc_bus i_soc_bus (
    .host_req_i  (apb_req_i),
    .host_resp_o (apb_resp_o),
    .l2_req_o    (l2_req),
    .l2_resp_i   (l2_resp),
    .cl_req_o    (cl_req),
    .cl_resp_i   (cl_resp)
  );

  l2_mem i_l2_mem (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (l2_req),
    .resp_o   (l2_resp)
  );

  cluster_ctrl i_cluster_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (cl_req),
    .resp_o     (cl_resp),
    .fetch_en_i (cl_fetch_en_i),
    .busy_o     (cl_busy_o),
    .eoc_o      (cl_eoc_o)
  );

endmodule

/* verification/tb_tests.svh */
/*
 * Stimulus and expected-value table for the SoC shell testbench
 */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// largest RUN value used by any entry
localparam int MAX_RUN = 64;

typedef enum logic [2:0] {
  OP_WRITE,
  OP_READ,
  OP_STATE,
  OP_POLL,
  OP_FETCH
} tb_op_e;

typedef logic [8*14-1:0] name_t;

typedef struct packed {
  name_t     name;
  tb_op_e    op;
  logic      rnd;
  apb_addr_t addr;
  apb_data_t data;
  apb_strb_t strb;
  apb_data_t exp;
  cl_state_e state;
  logic      err;
} test_t;

localparam int N_TESTS = 37;

// per entry name, op, random L2 data flag, addr, wdata, strobe, rdata, state and pslverr
test_t tests [N_TESTS] = '{
  '{"c0 rst idle", OP_STATE, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c1 rst idle", OP_STATE, 1'b0, 16'h1018, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 wr lo", OP_WRITE, 1'b1, 16'h0000, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 wr hi", OP_WRITE, 1'b1, 16'h03fc, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 wr mid", OP_WRITE, 1'b1, 16'h0100, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 rd lo", OP_READ, 1'b1, 16'h0000, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 rd hi", OP_READ, 1'b1, 16'h03fc, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 rd mid", OP_READ, 1'b1, 16'h0100, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  // partial strobes on a word that holds known data
  '{"l2 wr strb 5", OP_WRITE, 1'b1, 16'h0100, 32'h0, 4'h5, 32'h0, CL_IDLE, 1'b0},
  '{"l2 rd strb 5", OP_READ, 1'b1, 16'h0100, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"l2 wr strb 8", OP_WRITE, 1'b1, 16'h0100, 32'h0, 4'h8, 32'h0, CL_IDLE, 1'b0},
  '{"l2 rd strb 8", OP_READ, 1'b1, 16'h0100, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  // unmapped and out-of-range targets
  '{"unmapped rd", OP_READ, 1'b0, 16'h2000, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b1},
  '{"l2 edge wr", OP_WRITE, 1'b0, 16'h0400, 32'h12345678, 4'hf, 32'h0, CL_IDLE, 1'b1},
  '{"l2 edge rd", OP_READ, 1'b0, 16'h0400, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b1},
  // word 0 would be hit if the edge write aliased into L2
  '{"l2 lo kept", OP_READ, 1'b1, 16'h0000, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"cl idx 2 rd", OP_READ, 1'b0, 16'h1020, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b1},
  '{"cl idx 2 wr", OP_WRITE, 1'b0, 16'h1024, 32'h5, 4'hf, 32'h0, CL_IDLE, 1'b1},
  // cluster 0 run by command
  '{"c0 run wr", OP_WRITE, 1'b0, 16'h1004, 32'h5, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c0 run rd", OP_READ, 1'b0, 16'h1004, 32'h0, 4'hf, 32'h5, CL_IDLE, 1'b0},
  '{"c0 start", OP_WRITE, 1'b0, 16'h1000, 32'h1, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c0 busy", OP_POLL, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_BUSY, 1'b0},
  '{"c0 done", OP_POLL, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_DONE, 1'b0},
  // register errors while cluster 0 sits in done
  '{"bad opcode", OP_WRITE, 1'b0, 16'h1000, 32'h7f, 4'hf, 32'h0, CL_IDLE, 1'b1},
  // a clear opcode here must not reach the sequencer
  '{"status wr", OP_WRITE, 1'b0, 16'h1008, 32'h3, 4'hf, 32'h0, CL_IDLE, 1'b1},
  '{"cmd rd", OP_READ, 1'b0, 16'h1000, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b1},
  '{"c0 kept done", OP_STATE, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_DONE, 1'b0},
  '{"c0 clear", OP_WRITE, 1'b0, 16'h1000, 32'h3, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c0 idle", OP_STATE, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  // cluster 1 started by fetch-enable and then stopped
  '{"c1 run wr", OP_WRITE, 1'b0, 16'h1014, 32'(MAX_RUN), 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c1 fetch on", OP_FETCH, 1'b0, 16'h0000, 32'h2, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c1 busy", OP_POLL, 1'b0, 16'h1018, 32'h0, 4'hf, 32'h0, CL_BUSY, 1'b0},
  '{"c0 still idle", OP_STATE, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c1 fetch off", OP_FETCH, 1'b0, 16'h0000, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c1 stop", OP_WRITE, 1'b0, 16'h1010, 32'h2, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c1 idle", OP_STATE, 1'b0, 16'h1018, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0},
  '{"c0 end idle", OP_STATE, 1'b0, 16'h1008, 32'h0, 4'hf, 32'h0, CL_IDLE, 1'b0}
};

`endif

/* verification/tb_pulp_soc.sv */
/*
 * Testbench for the SoC shell, table-driven APB transfers with a shadow L2
 */
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_pulp_soc;

  import apb_pkg::*;
  import cluster_pkg::*;

  `include "tb_tests.svh"

  localparam int RESET_CYCLES = 4;
  localparam int POLL_BOUND   = MAX_RUN + 8;
  localparam int CYCLE_LIMIT  = N_TESTS * POLL_BOUND + RESET_CYCLES;
  localparam int CL_IDX_W     = $clog2(`SOC_N_CLUSTERS);
  localparam int L2_IDX_W     = $clog2(`SOC_L2_WORDS);

  logic                       clk = 1'b0;
  logic                       arst_n;
  apb_req_t                   apb_req;
  apb_resp_t                  apb_resp;
  logic [`SOC_N_CLUSTERS-1:0] fetch_en;
  logic [`SOC_N_CLUSTERS-1:0] busy;
  logic [`SOC_N_CLUSTERS-1:0] eoc;

  // outputs captured in the middle of the access cycle
  apb_resp_t                  resp_smp;
  logic [`SOC_N_CLUSTERS-1:0] busy_smp;
  logic [`SOC_N_CLUSTERS-1:0] eoc_smp;

  apb_data_t shadow [`SOC_L2_WORDS];
  int        seed   = 71;
  int        cycles = 0;

  pulp_soc i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .apb_req_i     (apb_req),
    .apb_resp_o    (apb_resp),
    .cl_fetch_en_i (fetch_en),
    .cl_busy_o     (busy),
    .cl_eoc_o      (eoc)
  );

  always #20 clk = ~clk;

  task automatic stop_on_error();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  task automatic check_data(input name_t name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_err(input name_t name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected pslverr %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input name_t name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected flag %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_state(input name_t name, input cl_state_e exp, input cl_state_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s, actual %s", name, exp.name(), act.name());
      stop_on_error();
    end
  endtask

  // setup cycle, access cycle, then back to idle
  task automatic apb_xfer(input name_t name, input logic wr, input apb_addr_t addr,
                          input apb_data_t wdata, input apb_strb_t strb);
    @(posedge clk);
    apb_req <= '{addr, 1'b1, 1'b0, wr, wdata, strb};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    resp_smp = apb_resp;
    busy_smp = busy;
    eoc_smp  = eoc;
    @(posedge clk);
    apb_req <= '0;
    check_flag(name, 1'b1, resp_smp.pready);
  endtask

  // STATUS value plus the matching busy and eoc outputs
  task automatic check_cluster(input test_t t);
    logic [CL_IDX_W-1:0] idx;
    idx = CL_IDX_W'((t.addr - `SOC_CL_BASE) / `SOC_CL_STRIDE);
    check_err(t.name, t.err, resp_smp.pslverr);
    check_state(t.name, t.state, cl_state_e'(resp_smp.prdata[1:0]));
    check_data(t.name, apb_data_t'(t.state), resp_smp.prdata);
    check_flag(t.name, t.state == CL_BUSY, busy_smp[idx]);
    check_flag(t.name, t.state == CL_DONE, eoc_smp[idx]);
  endtask

  task automatic apply_test(input test_t t);
    apb_data_t           wdata;
    apb_data_t           exp;
    logic [L2_IDX_W-1:0] widx;
    int                  reads;
    logic                found;
    widx = t.addr[L2_IDX_W+1:2];
    case (t.op)
      OP_WRITE: begin
        wdata = t.rnd ? apb_data_t'($random(seed)) : t.data;
        apb_xfer(t.name, 1'b1, t.addr, wdata, t.strb);
        check_err(t.name, t.err, resp_smp.pslverr);
        if (t.rnd) begin
          for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (t.strb[b]) begin
              shadow[widx][8*b +: 8] = wdata[8*b +: 8];
            end
          end
        end
      end
      OP_READ: begin
        exp = t.rnd ? shadow[widx] : t.exp;
        apb_xfer(t.name, 1'b0, t.addr, '0, '0);
        check_err(t.name, t.err, resp_smp.pslverr);
        check_data(t.name, exp, resp_smp.prdata);
      end
      OP_STATE: begin
        apb_xfer(t.name, 1'b0, t.addr, '0, '0);
        check_cluster(t);
      end
      OP_POLL: begin
        reads = 0;
        found = 1'b0;
        while (!found && reads < POLL_BOUND) begin
          apb_xfer(t.name, 1'b0, t.addr, '0, '0);
          reads++;
          found = !resp_smp.pslverr && resp_smp.prdata[1:0] == t.state;
        end
        if (!found) begin
          $display("poll %s never reached the expected state in %0d reads", t.name, reads);
          stop_on_error();
        end
        check_cluster(t);
      end
      default: begin
        @(posedge clk);
        fetch_en <= t.data[`SOC_N_CLUSTERS-1:0];
      end
    endcase
  endtask

  initial begin
    apb_req  = '0;
    fetch_en = '0;
    arst_n   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      apply_test(tests[i]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+rtl
+incdir+verification
rtl/apb_pkg.sv
rtl/cluster_pkg.sv
rtl/l2_mem.sv
rtl/cluster_fsm.sv
rtl/cluster_ctrl.sv
rtl/soc_bus.sv
rtl/pulp_soc.sv
verification/tb_pulp_soc.sv

/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
TOP        := tb_pulp_soc
FILE_LIST  := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
